// ==== dfpEncodingPkg.sv ====
// Encoded 96-bit decimal floating point format: field layout, limits and DPD declet coding.
// Imported by the unpack and pack stages, which convert between this form and the record.
`default_nettype none

package dfpEncodingPkg;

	// ------------------------------
	// Format widths and limits
	// ------------------------------
	localparam int DfpWordBits = 96;
	localparam int DfpDigits = 25;
	localparam int DfpExpBits = 12;
	localparam int DfpDeclets = 8;
	localparam int DfpCoefContBits = 80;
	localparam int DfpPayloadBits = 89;

	// Stored exponents are biased, so an unbiased view subtracts this value
	localparam logic [DfpExpBits-1:0] DfpExpBias = 12'h5FF;
	// Top exponent bits 11 would collide with the 11xx combination form
	localparam logic [DfpExpBits-1:0] DfpExpMax = 12'hBFF;

	// Combination field codes reserved for specials
	localparam logic [4:0] DfpComboInf = 5'b11110;
	localparam logic [4:0] DfpComboNan = 5'b11111;

	// ------------------------------
	// Word layout
	// ------------------------------
	// Finite numbers carry two exponent bits and the leading digit in the combination field
	typedef struct packed {
		logic sign;
		logic [4:0] combo;
		logic [9:0] expCont;
		logic [DfpCoefContBits-1:0] coefCont;
	} dfpFiniteFields;

	// Specials reuse the combination field as a code, then the quiet or signalling bit
	typedef struct packed {
		logic sign;
		logic [4:0] code;
		logic signalling;
		logic [DfpPayloadBits-1:0] payload;
	} dfpSpecialFields;

	// The same 96 bits read either as a finite number or as a special
	typedef union packed {
		dfpFiniteFields finiteView;
		dfpSpecialFields specialView;
	} dfpWord;

	// ------------------------------
	// DPD declet coding
	// ------------------------------
	// One declet holds three digits; v clear means all three are small (0..7)
	function automatic logic [11:0] dpdToBcd(input logic [9:0] declet);
		logic p, q, r, s, t, u, v, w, x, y;
		logic [3:0] d2, d1, d0;
		{p, q, r, s, t, u, v, w, x, y} = declet;
		d2 = {1'b0, p, q, r};
		d1 = {1'b0, s, t, u};
		d0 = {1'b0, w, x, y};
		if (v) begin
			// Bits wx tell which digit is large, 11 defers to st for two or three
			case ({w, x})
				2'b00: d0 = {3'b100, y};
				2'b01: begin
					d1 = {3'b100, u};
					d0 = {1'b0, s, t, y};
				end
				2'b10: begin
					d2 = {3'b100, r};
					d0 = {1'b0, p, q, y};
				end
				default: begin
					case ({s, t})
						2'b00: begin
							d2 = {3'b100, r};
							d1 = {3'b100, u};
							d0 = {1'b0, p, q, y};
						end
						2'b01: begin
							d2 = {3'b100, r};
							d1 = {1'b0, p, q, u};
							d0 = {3'b100, y};
						end
						2'b10: begin
							d1 = {3'b100, u};
							d0 = {3'b100, y};
						end
						default: begin
							d2 = {3'b100, r};
							d1 = {3'b100, u};
							d0 = {3'b100, y};
						end
					endcase
				end
			endcase
		end
		return {d2, d1, d0};
	endfunction

	// Inverse of the above, selected by which of the three digits are 8 or 9
	function automatic logic [9:0] bcdToDpd(input logic [11:0] digits);
		logic a, b, c, d, e, f, g, h, i, j, k, m;
		logic [9:0] declet;
		{a, b, c, d} = digits[11:8];
		{e, f, g, h} = digits[7:4];
		{i, j, k, m} = digits[3:0];
		case ({a, e, i})
			3'b000: declet = {b, c, d, f, g, h, 1'b0, j, k, m};
			3'b001: declet = {b, c, d, f, g, h, 1'b1, 1'b0, 1'b0, m};
			3'b010: declet = {b, c, d, j, k, h, 1'b1, 1'b0, 1'b1, m};
			3'b011: declet = {b, c, d, 1'b1, 1'b0, h, 1'b1, 1'b1, 1'b1, m};
			3'b100: declet = {j, k, d, f, g, h, 1'b1, 1'b1, 1'b0, m};
			3'b101: declet = {f, g, d, 1'b0, 1'b1, h, 1'b1, 1'b1, 1'b1, m};
			3'b110: declet = {j, k, d, 1'b0, 1'b0, h, 1'b1, 1'b1, 1'b1, m};
			default: declet = {1'b0, 1'b0, d, 1'b1, 1'b1, h, 1'b1, 1'b1, 1'b1, m};
		endcase
		return declet;
	endfunction

	// Builds a finite word from sign, biased exponent and 25 BCD digits
	function automatic dfpWord encodeFinite(input logic sign, input logic [DfpExpBits-1:0] exp,
			input logic [DfpDigits*4-1:0] sig);
		dfpWord word;
		logic [3:0] lead;
		word = '0;
		lead = sig[DfpDigits*4-1 -: 4];
		word.finiteView.sign = sign;
		// Leading digit 8 or 9 needs only its low bit, so it takes the 11xx form
		if (lead[3])
			word.finiteView.combo = {2'b11, exp[DfpExpBits-1 -: 2], lead[0]};
		else
			word.finiteView.combo = {exp[DfpExpBits-1 -: 2], lead[2:0]};
		word.finiteView.expCont = exp[9:0];
		for (int n = 0; n < DfpDeclets; n++)
			word.finiteView.coefCont[n*10 +: 10] = bcdToDpd(sig[n*12 +: 12]);
		return word;
	endfunction

endpackage

`default_nettype wire

// ==== dfpInternalPkg.sv ====
// Widths and codes of the unpacked record as it moves through the scaling pipeline.
`default_nettype none

package dfpInternalPkg;

	// 25 digits of four BCD bits each
	localparam int DfpSigBits = 100;

	// Signed sum of exponent and scale, with a guard bit above the 12-bit exponent
	localparam int DfpWorkExpBits = 14;

	// Scale factors beyond this magnitude already force underflow or overflow
	localparam int DfpScaleClamp = 8191;

	// ------------------------------
	// Operand kind in stage 1
	// ------------------------------
	// One code replaces the nan, snan, qnan and infinity flags between the stages
	localparam int DfpKindBits = 2;
	localparam logic [DfpKindBits-1:0] DfpKindFinite = 2'd0;
	localparam logic [DfpKindBits-1:0] DfpKindInf = 2'd1;
	localparam logic [DfpKindBits-1:0] DfpKindQnan = 2'd2;
	localparam logic [DfpKindBits-1:0] DfpKindSnan = 2'd3;

endpackage

`default_nettype wire

// ==== dfpUnpackedIf.sv ====
// One unpacked decimal value passed between blocks: flags, sign, exponent and BCD digits.
`timescale 1ns/1ps
`default_nettype none

interface dfpUnpackedIf
	import dfpEncodingPkg::*, dfpInternalPkg::*;
();

	// Special-value flags; snan and qnan are only meaningful with nan
	logic nan;
	logic snan;
	logic qnan;
	logic infinity;

	logic sign;
	// Biased exponent, zero for specials
	logic [DfpExpBits-1:0] exp;
	// BCD digits, or the raw NaN payload in the low bits
	logic [DfpSigBits-1:0] sig;

	// The producing block drives every field
	modport source (
		output nan, snan, qnan, infinity, sign, exp, sig
	);

	// The consuming block only reads
	modport sink (
		input nan, snan, qnan, infinity, sign, exp, sig
	);

endinterface

`default_nettype wire

// ==== dfpUnpack96.sv ====
// Combinational decode of a 96-bit DPD word into the unpacked record.
`timescale 1ns/1ps
`default_nettype none

module dfpUnpack96
	import dfpEncodingPkg::*, dfpInternalPkg::*;
(
	input dfpWord a,
	dfpUnpackedIf.source u
);

	logic [4:0] combo;
	logic [1:0] expTop;
	logic [3:0] leadDigit;
	logic isInf;
	logic isNan;

	// Combination field sits at the same bits in both views
	assign combo = a.finiteView.combo;
	assign isInf = a.specialView.code == DfpComboInf;
	assign isNan = a.specialView.code == DfpComboNan;

	// ------------------------------
	// Combination field
	// ------------------------------
	always_comb begin
		if (combo[4:3] == 2'b11) begin
			// 11xx form: exponent bits move down, leading digit is 8 or 9
			expTop = combo[2:1];
			leadDigit = {3'b100, combo[0]};
		end else begin
			expTop = combo[4:3];
			leadDigit = {1'b0, combo[2:0]};
		end
	end

	// ------------------------------
	// Record fields
	// ------------------------------
	always_comb begin
		u.sign = a.finiteView.sign;
		u.nan = isNan;
		u.snan = isNan && a.specialView.signalling;
		u.qnan = isNan && !a.specialView.signalling;
		u.infinity = isInf;
		u.exp = '0;
		u.sig = '0;
		if (isNan) begin
			// Payload travels untouched so non-canonical declets survive
			u.sig[DfpPayloadBits-1:0] = a.specialView.payload;
		end else if (!isInf) begin
			u.exp = {expTop, a.finiteView.expCont};
			u.sig[DfpSigBits-1 -: 4] = leadDigit;
			// Declet 0 holds the three least significant digits
			for (int i = 0; i < DfpDeclets; i++)
				u.sig[i*12 +: 12] = dpdToBcd(a.finiteView.coefCont[i*10 +: 10]);
		end
	end

endmodule

`default_nettype wire

// ==== dfpScaleCore.sv ====
// Two-stage exponent adjustment for scaleb: stage 1 adds the clamped scale, stage 2
// resolves NaN, infinity, underflow and overflow. Both stages advance only with ce.
`timescale 1ns/1ps
`default_nettype none

module dfpScaleCore
	import dfpEncodingPkg::*, dfpInternalPkg::*;
(
	input logic clk,
	input logic reset,
	input logic ce,
	input logic signed [31:0] b,
	dfpUnpackedIf.sink src,
	dfpUnpackedIf.source dst
);

	logic signed [31:0] bClamped;
	logic signed [DfpWorkExpBits:0] sumWide;
	logic signed [DfpWorkExpBits-1:0] sumSat;
	logic [DfpKindBits-1:0] kindIn;

	// Stage 1 registers
	logic [DfpKindBits-1:0] kind1;
	logic sign1;
	logic [DfpExpBits-1:0] exp1;
	logic signed [DfpWorkExpBits-1:0] sum1;
	logic [DfpSigBits-1:0] sig1;

	// Stage 2 registers
	logic nan2;
	logic snan2;
	logic qnan2;
	logic inf2;
	logic sign2;
	logic [DfpExpBits-1:0] exp2;
	logic [DfpSigBits-1:0] sig2;

	// ------------------------------
	// Stage 1
	// ------------------------------
	// Beyond the clamp every result is already pinned to zero or infinity
	always_comb begin
		if (b > DfpScaleClamp)
			bClamped = DfpScaleClamp;
		else if (b < -DfpScaleClamp)
			bClamped = -DfpScaleClamp;
		else
			bClamped = b;
	end

	// Add one bit wider, since exponent plus the full clamp can pass the working range
	assign sumWide = $signed({{(DfpWorkExpBits + 1 - DfpExpBits){1'b0}}, src.exp})
		+ $signed(bClamped[DfpWorkExpBits:0]);

	// Only the positive side can overflow; pinning it still reads as overflow later
	always_comb begin
		if (sumWide[DfpWorkExpBits] == sumWide[DfpWorkExpBits-1])
			sumSat = sumWide[DfpWorkExpBits-1:0];
		else
			sumSat = {1'b0, {(DfpWorkExpBits - 1){1'b1}}};
	end

	// Fold the flags into one kind code
	always_comb begin
		if (src.nan)
			kindIn = src.snan ? DfpKindSnan : DfpKindQnan;
		else if (src.infinity)
			kindIn = DfpKindInf;
		else
			kindIn = DfpKindFinite;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			kind1 <= DfpKindFinite;
			sign1 <= 1'b0;
			exp1 <= '0;
			sum1 <= '0;
			sig1 <= '0;
		end else if (ce) begin
			kind1 <= kindIn;
			sign1 <= src.sign;
			exp1 <= src.exp;
			sum1 <= sumSat;
			sig1 <= src.sig;
		end
	end

	// ------------------------------
	// Stage 2
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			nan2 <= 1'b0;
			snan2 <= 1'b0;
			qnan2 <= 1'b0;
			inf2 <= 1'b0;
			sign2 <= 1'b0;
			exp2 <= '0;
			sig2 <= '0;
		end else if (ce) begin
			nan2 <= 1'b0;
			snan2 <= 1'b0;
			qnan2 <= 1'b0;
			inf2 <= 1'b0;
			sign2 <= sign1;
			exp2 <= exp1;
			sig2 <= sig1;
			case (kind1)
				// NaN keeps exponent and payload as they came in
				DfpKindQnan, DfpKindSnan: begin
					nan2 <= 1'b1;
					snan2 <= kind1 == DfpKindSnan;
					qnan2 <= kind1 == DfpKindQnan;
				end
				DfpKindInf: begin
					inf2 <= 1'b1;
					exp2 <= DfpExpMax;
					sig2 <= '0;
				end
				default: begin
					if (sum1[DfpWorkExpBits-1]) begin
						// Underflow limits the exponent, the digits are not shifted
						exp2 <= '0;
					end else if (sum1 > $signed({{(DfpWorkExpBits - DfpExpBits){1'b0}},
							DfpExpMax})) begin
						inf2 <= 1'b1;
						exp2 <= DfpExpMax;
						sig2 <= '0;
					end else begin
						exp2 <= sum1[DfpExpBits-1:0];
					end
				end
			endcase
		end
	end

	assign dst.nan = nan2;
	assign dst.snan = snan2;
	assign dst.qnan = qnan2;
	assign dst.infinity = inf2;
	assign dst.sign = sign2;
	assign dst.exp = exp2;
	assign dst.sig = sig2;

	// The kind fold would hide a NaN that also claims infinity or both NaN kinds
	assert property (@(posedge clk) disable iff (reset) !(src.nan && src.infinity))
		else $error("NaN and infinity both set at the core input");
	assert property (@(posedge clk) disable iff (reset)
		!(src.snan && src.qnan) && ((src.snan || src.qnan) == src.nan))
		else $error("NaN kind flags inconsistent at the core input");

endmodule

`default_nettype wire

// ==== dfpPack96.sv ====
// Combinational encode of the unpacked record back into a 96-bit DPD word.
`timescale 1ns/1ps
`default_nettype none

module dfpPack96
	import dfpEncodingPkg::*;
(
	dfpUnpackedIf.sink u,
	output dfpWord o
);

	logic digitsValid;

	// ------------------------------
	// Word assembly
	// ------------------------------
	always_comb begin
		o = '0;
		if (u.nan) begin
			o.specialView.sign = u.sign;
			o.specialView.code = DfpComboNan;
			// Quiet or signalling kind goes back into the bit after the code
			o.specialView.signalling = u.snan;
			o.specialView.payload = u.sig[DfpPayloadBits-1:0];
		end else if (u.infinity) begin
			// Infinity carries no payload
			o.specialView.sign = u.sign;
			o.specialView.code = DfpComboInf;
		end else begin
			o = encodeFinite(u.sign, u.exp, u.sig);
		end
	end

	// ------------------------------
	// Digit check
	// ------------------------------
	// Any digit above 9 would encode to a declet that decodes differently
	always_comb begin
		digitsValid = 1'b1;
		for (int i = 0; i < DfpDigits; i++) begin
			if (u.sig[i*4 +: 4] > 4'd9)
				digitsValid = 1'b0;
		end
	end

	// Finite digits come from the unpack decode through the core unchanged
	always_comb begin
		assert #0 (u.nan || u.infinity || digitsValid)
			else $error("Finite coefficient holds a digit above 9");
	end

endmodule

`default_nettype wire

// ==== dfpScaleb96.sv ====
// Top level of the scaleb unit: o = a * 10**b for 96-bit decimal floating point.
// Two ce-gated pipeline stages between a, b and o.
`timescale 1ns/1ps
`default_nettype none

module dfpScaleb96
	import dfpEncodingPkg::*;
(
	input logic clk,
	input logic reset,
	input logic ce,
	input logic [DfpWordBits-1:0] a,
	input logic signed [31:0] b,
	output logic [DfpWordBits-1:0] o
);

	// Decoded operand into the core, and the scaled record out of it
	dfpUnpackedIf unpackBus ();
	dfpUnpackedIf scaledBus ();

	// Decode is purely combinational
	dfpUnpack96 u_dfpUnpack96 (
		.a (a),
		.u (unpackBus.source)
	);

	// Both pipeline stages live here
	dfpScaleCore u_dfpScaleCore (
		.clk   (clk),
		.reset (reset),
		.ce    (ce),
		.b     (b),
		.src   (unpackBus.sink),
		.dst   (scaledBus.source)
	);

	// Output follows stage 2 without a further register
	dfpPack96 u_dfpPack96 (
		.u (scaledBus.sink),
		.o (o)
	);

endmodule

`default_nettype wire

// ==== dfpScalebTb.sv ====
// Self-checking testbench for the scaleb unit: random and corner operands, ce gaps and reset.
// A reference function predicts each word and a checking process follows the two-stage pipe.
`timescale 1ns/1ps
`default_nettype none

module dfpScalebTb
	import dfpEncodingPkg::*;
();

	// ------------------------------
	// Run length
	// ------------------------------
	localparam int NumInRange = 40;
	localparam int NumUnder = 12;
	localparam int NumOver = 12;
	localparam int NumSpecial = 16;
	localparam int NumCeMix = 20;
	localparam int MaxGap = 3;
	// Reset, corner cases, the worst case of the ce gaps, the drain and the closing reset
	localparam int PlannedCycles = 2 + NumInRange + 2 + NumUnder + 3 + NumOver + 5
		+ NumSpecial + NumCeMix * (1 + MaxGap) + 4 + 7;
	localparam int WatchdogNs = PlannedCycles * 8 * 4 + 500;

	logic clk = 1'b0;
	logic reset;
	logic ce;
	logic [DfpWordBits-1:0] a;
	logic signed [31:0] b;
	logic [DfpWordBits-1:0] o;

	logic [31:0] rngState;
	// Expected words in capture order, with the name of the test that issued them
	logic [DfpWordBits-1:0] expQ[$];
	string nameQ[$];
	int issuedCount = 0;
	int doneCount = 0;
	int checkCount = 0;
	int valueErrors = 0;

	dfpScaleb96 u_dfpScaleb96 (
		.clk   (clk),
		.reset (reset),
		.ce    (ce),
		.a     (a),
		.b     (b),
		.o     (o)
	);

	always #4 clk = ~clk;

	// ------------------------------
	// Random numbers and operands
	// ------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] randWord();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// 25 random digits, so the leading digit also hits the 8 and 9 form
	function logic [DfpWordBits-1:0] randomFinite(input logic sign, input logic [11:0] exp);
		logic [DfpDigits*4-1:0] sig;
		for (int i = 0; i < DfpDigits; i++)
			sig[i*4 +: 4] = 4'(randWord() % 10);
		return encodeFinite(sign, exp, sig);
	endfunction

	function logic [DfpWordBits-1:0] makeNan(input logic sign, input logic signalling);
		logic [95:0] raw;
		raw = {randWord(), randWord(), randWord()};
		return {sign, DfpComboNan, signalling, raw[88:0]};
	endfunction

	// Trailing bits are random here, the result must still come out clean
	function logic [DfpWordBits-1:0] makeInf(input logic sign);
		logic [95:0] raw;
		raw = {randWord(), randWord(), randWord()};
		return {sign, DfpComboInf, raw[89:0]};
	endfunction

	// ------------------------------
	// Reference model
	// ------------------------------
	// Works on the encoded fields: only the exponent moves, so the declets never change
	function automatic logic [DfpWordBits-1:0] refScaleb(input logic [DfpWordBits-1:0] aw,
			input logic signed [31:0] bw);
		logic [4:0] combo;
		logic [11:0] expIn;
		logic [11:0] expOut;
		longint sum;
		logic [DfpWordBits-1:0] res;
		combo = aw[94:90];
		// NaN leaves unchanged, infinity loses its trailing bits
		if (combo == DfpComboNan)
			return aw;
		if (combo == DfpComboInf)
			return {aw[95], DfpComboInf, 90'd0};
		if (combo[4:3] == 2'b11)
			expIn = {combo[2:1], aw[89:80]};
		else
			expIn = {combo[4:3], aw[89:80]};
		sum = longint'(expIn) + longint'(bw);
		if (sum > longint'(DfpExpMax))
			return {aw[95], DfpComboInf, 90'd0};
		// Underflow stops at zero without touching the digits
		expOut = (sum < 0) ? 12'd0 : 12'(sum);
		res = aw;
		if (combo[4:3] == 2'b11)
			res[94:90] = {2'b11, expOut[11:10], combo[0]};
		else
			res[94:90] = {expOut[11:10], combo[2:0]};
		res[89:80] = expOut[9:0];
		return res;
	endfunction

	// ------------------------------
	// Stimulus
	// ------------------------------
	task automatic issueOp(input logic [DfpWordBits-1:0] aw, input logic signed [31:0] bw,
			input string name);
		@(posedge clk);
		#1;
		a = aw;
		b = bw;
		ce = 1'b1;
		expQ.push_back(refScaleb(aw, bw));
		nameQ.push_back(name);
		issuedCount++;
	endtask

	// Garbage on a and b while ce is low must never be captured
	task automatic holdCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			ce = 1'b0;
			a = {randWord(), randWord(), randWord()};
			b = randWord();
		end
	endtask

	// Reset wins over ce, with garbage on the inputs and live results in both stages
	task automatic resetPipeline(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			reset = 1'b1;
			ce = 1'b1;
			a = {randWord(), randWord(), randWord()};
			b = randWord();
		end
		@(posedge clk);
		#1;
		reset = 1'b0;
		ce = 1'b0;
	endtask

	task automatic runInRange();
		logic [11:0] exp;
		for (int i = 0; i < NumInRange; i++) begin
			exp = 12'(randWord() % 2800 + 100);
			issueOp(randomFinite(randWord() % 2 == 1, exp), int'(randWord() % 41) - 20, "inRange");
		end
		// Sums landing exactly on the largest exponent and on zero
		issueOp(randomFinite(1'b0, 12'd1000), 32'sd2071, "inRangeTop");
		issueOp(randomFinite(1'b1, 12'd1000), -32'sd1000, "inRangeZero");
	endtask

	task automatic runUnderflow();
		logic [11:0] exp;
		for (int i = 0; i < NumUnder; i++) begin
			exp = 12'(randWord() % 3072);
			issueOp(randomFinite(randWord() % 2 == 1, exp),
				-(int'(exp) + 1 + int'(randWord() % 200)), "underflow");
		end
		issueOp(randomFinite(1'b0, 12'd0), -32'sd1, "underflowEdge");
		issueOp(randomFinite(1'b1, 12'd3000), -32'sd100000, "underflowHuge");
		issueOp(randomFinite(1'b0, DfpExpMax), 32'sh80000000, "underflowMin");
	endtask

	task automatic runOverflow();
		logic [11:0] exp;
		for (int i = 0; i < NumOver; i++) begin
			exp = 12'(randWord() % 3072);
			issueOp(randomFinite(randWord() % 2 == 1, exp),
				3072 - int'(exp) + int'(randWord() % 3), "overflow");
		end
		issueOp(randomFinite(1'b1, DfpExpMax), 32'sd1, "overflowEdge");
		issueOp(randomFinite(1'b0, 12'd0), 32'sd8192, "overflowClamp");
		issueOp(randomFinite(1'b0, DfpExpMax), 32'sd8191, "overflowSat");
		issueOp(randomFinite(1'b1, 12'd5), 32'sd100000, "overflowHuge");
		issueOp(randomFinite(1'b0, 12'd5), 32'sh7FFFFFFF, "overflowMax");
	endtask

	// Any b at all, including the extremes of the 32-bit range
	task automatic runSpecials();
		logic sign;
		for (int i = 0; i < NumSpecial; i++) begin
			sign = randWord() % 2 == 1;
			case (i % 4)
				0: issueOp(makeNan(sign, 1'b0), randWord(), "quietNan");
				1: issueOp(makeNan(sign, 1'b1), randWord(), "signallingNan");
				2: issueOp(makeInf(sign), randWord(), "infinity");
				default: issueOp(makeInf(sign), -32'sd100000, "infinityDown");
			endcase
		end
	endtask

	task automatic runCeGaps();
		int gap;
		for (int i = 0; i < NumCeMix; i++) begin
			gap = int'(randWord() % (MaxGap + 1));
			holdCycles(gap);
			issueOp(randomFinite(randWord() % 2 == 1, 12'(randWord() % 3000 + 30)),
				int'(randWord() % 41) - 20, "ceGaps");
		end
	endtask

	// ------------------------------
	// Checking
	// ------------------------------
	// Mirrors the two stages; ce and reset are read at the edge, o at the falling edge
	initial begin
		logic [DfpWordBits-1:0] s1Exp;
		logic [DfpWordBits-1:0] s2Exp;
		string s1Name;
		string s2Name;
		bit s1Valid;
		bit fresh;
		s1Exp = '0;
		s2Exp = '0;
		s1Name = "reset";
		s2Name = "reset";
		s1Valid = 1'b0;
		forever begin
			@(posedge clk);
			fresh = 1'b0;
			if (reset) begin
				// Cleared registers encode positive zero with exponent zero
				s1Exp = '0;
				s2Exp = '0;
				s1Name = "reset";
				s2Name = "reset";
				s1Valid = 1'b0;
			end else if (ce) begin
				s2Exp = s1Exp;
				s2Name = s1Name;
				fresh = s1Valid;
				s1Exp = expQ.pop_front();
				s1Name = nameQ.pop_front();
				s1Valid = 1'b1;
			end
			@(negedge clk);
			checkCount++;
			assert (o === s2Exp) else begin
				valueErrors++;
				$display("ERR %s expected %h actual %h", s2Name, s2Exp, o);
			end
			if (fresh)
				doneCount++;
		end
	end

	// ------------------------------
	// Sequence and watchdog
	// ------------------------------
	initial begin
		int target;
		rngState = 32'd98;
		reset = 1'b1;
		ce = 1'b0;
		a = '0;
		b = '0;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		runInRange();
		runUnderflow();
		runOverflow();
		runSpecials();
		runCeGaps();
		// Push zeros until every real operation has reached o and been compared
		target = issuedCount;
		while (doneCount < target)
			issueOp('0, 32'sd0, "drain");
		// Reset with live results in both stages must still clear o
		issueOp(randomFinite(1'b1, 12'd2000), 32'sd5, "resetFlush");
		issueOp(randomFinite(1'b0, 12'd1500), -32'sd5, "resetFlush");
		resetPipeline(2);
		repeat (2) @(posedge clk);
		$display("checks %0d, value errors %0d", checkCount, valueErrors);
		if (valueErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	initial begin
		#WatchdogNs;
		$display("Watchdog expired before all results were checked");
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
dfpEncodingPkg.sv
dfpInternalPkg.sv
dfpUnpackedIf.sv
dfpUnpack96.sv
dfpScaleCore.sv
dfpPack96.sv
dfpScaleb96.sv
dfpScalebTb.sv

// ==== Makefile ====
# Verilator build and run of the scaleb testbench

TOP = dfpScalebTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
